// ==== hw/mem_pkg.sv ====
package mem_pkg;

    localparam int unsigned data_w = 32;
    localparam int unsigned strb_w = data_w / 8;
    localparam int unsigned addr_w = 32;

    // One APB requester-to-completer bundle.
    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [addr_w-1:0] paddr;
        logic [data_w-1:0] pwdata;
        logic [strb_w-1:0] pstrb;
    } apb_req_t;

    typedef struct packed {
        logic [data_w-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

    // Word-addressed RAM access.
    typedef struct packed {
        logic              en;
        logic              we;
        logic [addr_w-3:0] addr;   // Byte address without bits 1:0.
        logic [data_w-1:0] wdata;
        logic [strb_w-1:0] wmask;
    } mem_req_t;

    typedef enum logic [1:0] {
        ARB_IDLE  = 2'd0,
        ARB_ISSUE = 2'd1,
        ARB_DONE  = 2'd2
    } arb_state_e;

    typedef enum logic {
        PORT_FETCH = 1'b0,
        PORT_DATA  = 1'b1
    } port_e;

endpackage

// ==== hw/lane_align.sv ====
`timescale 1ns/1ps

module lane_align (
    input  logic              clk,
    input  logic              rst_n,
    input  mem_pkg::apb_req_t data_req,
    output mem_pkg::apb_req_t lane_req,
    input  mem_pkg::apb_rsp_t lane_rsp,
    output mem_pkg::apb_rsp_t data_rsp
);
    import mem_pkg::*;

    logic [1:0]          offset;
    logic [2*strb_w-1:0] strb_wide;
    logic [data_w-1:0]   wdata_lane;
    logic [data_w-1:0]   rdata_down;

    assign offset = data_req.paddr[1:0];

    // Upper half catches strobe bits pushed past lane 3.
    assign strb_wide = {{strb_w{1'b0}}, data_req.pstrb} << offset;

    always_comb begin
        case (offset)
            2'd0: begin
                wdata_lane = data_req.pwdata;
                rdata_down = lane_rsp.prdata;
            end
            2'd1: begin
                wdata_lane = {data_req.pwdata[data_w-9:0], 8'b0};
                rdata_down = {8'b0, lane_rsp.prdata[data_w-1:8]};
            end
            2'd2: begin
                wdata_lane = {data_req.pwdata[data_w-17:0], 16'b0};
                rdata_down = {16'b0, lane_rsp.prdata[data_w-1:16]};
            end
            default: begin
                wdata_lane = {data_req.pwdata[data_w-25:0], 24'b0};
                rdata_down = {24'b0, lane_rsp.prdata[data_w-1:24]};
            end
        endcase
    end

    always_comb begin
        lane_req        = data_req;   // Control fields pass unchanged.
        lane_req.pwdata = wdata_lane;
        lane_req.pstrb  = strb_wide[strb_w-1:0];
    end

    always_comb begin
        data_rsp        = lane_rsp;
        data_rsp.prdata = rdata_down;
    end

    // An access may not spill into the next word.
    no_word_cross: assert property (
        @(posedge clk) disable iff (!rst_n)
        (data_req.psel && data_req.penable) |-> (strb_wide[2*strb_w-1:strb_w] == '0)
    ) else $error("lane_align: access at 0x%08h crosses a word boundary", data_req.paddr);

endmodule

// ==== hw/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                       clk,
    input  logic                       rst_n,
    input  mem_pkg::apb_req_t          fetch_req,
    input  mem_pkg::apb_req_t          lane_req,
    output mem_pkg::apb_rsp_t          fetch_rsp,
    output mem_pkg::apb_rsp_t          lane_rsp,
    output mem_pkg::mem_req_t          ram_req,
    input  logic [mem_pkg::data_w-1:0] ram_rdata
);
    import mem_pkg::*;

    arb_state_e state_q;
    arb_state_e state_d;
    port_e      grant_q;
    port_e      grant_d;
    port_e      last_q;
    logic       fetch_act;
    logic       data_act;
    logic       fetch_bad;
    apb_req_t   sel_req;

    assign fetch_act = fetch_req.psel && fetch_req.penable;
    assign data_act  = lane_req.psel && lane_req.penable;

    // Round-robin on a tie, else whoever asks.
    always_comb begin
        if (fetch_act && data_act) begin
            grant_d = (last_q == PORT_FETCH) ? PORT_DATA : PORT_FETCH;
        end else if (fetch_act) begin
            grant_d = PORT_FETCH;
        end else begin
            grant_d = PORT_DATA;
        end
    end

    assign fetch_bad = (grant_d == PORT_FETCH) && fetch_req.pwrite;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ARB_IDLE: begin
                if (fetch_act || data_act) begin
                    state_d = fetch_bad ? ARB_DONE : ARB_ISSUE;   // Fetch writes skip the RAM.
                end
            end
            ARB_ISSUE: state_d = ARB_DONE;
            default:   state_d = ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ARB_IDLE;
            grant_q <= PORT_FETCH;
            last_q  <= PORT_DATA;   // Fetch wins the first tie.
        end else begin
            state_q <= state_d;
            if (state_q == ARB_IDLE && (fetch_act || data_act)) begin
                grant_q <= grant_d;
            end
            if (state_q == ARB_DONE) begin
                last_q <= grant_q;
            end
        end
    end

    assign sel_req = (grant_q == PORT_FETCH) ? fetch_req : lane_req;

    always_comb begin
        ram_req.en    = (state_q == ARB_ISSUE);
        ram_req.addr  = sel_req.paddr[addr_w-1:2];
        ram_req.wdata = sel_req.pwdata;
        if (grant_q == PORT_FETCH) begin
            ram_req.we    = 1'b0;
            ram_req.wmask = '1;   // Fetch always reads the full word.
        end else begin
            ram_req.we    = sel_req.pwrite;
            ram_req.wmask = sel_req.pstrb;
        end
    end

    always_comb begin
        fetch_rsp.prdata  = ram_rdata;
        fetch_rsp.pready  = (state_q == ARB_DONE) && (grant_q == PORT_FETCH);
        fetch_rsp.pslverr = fetch_rsp.pready && fetch_req.pwrite;
        lane_rsp.prdata   = ram_rdata;
        lane_rsp.pready   = (state_q == ARB_DONE) && (grant_q == PORT_DATA);
        lane_rsp.pslverr  = 1'b0;
    end

    // A pready only answers a port that is in its access phase.
    ready_to_active: assert property (
        @(posedge clk) disable iff (!rst_n)
        (!fetch_rsp.pready || fetch_act) && (!lane_rsp.pready || data_act)
    ) else $error("mem_arbiter: pready for a port with no transfer in progress");

    // The granted requester must hold its request until pready.
    fetch_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state_q != ARB_IDLE && grant_q == PORT_FETCH) |-> $stable(fetch_req)
    ) else $error("mem_arbiter: fetch request changed before pready");

    data_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state_q != ARB_IDLE && grant_q == PORT_DATA) |-> $stable(lane_req)
    ) else $error("mem_arbiter: data request changed before pready");

endmodule

// ==== hw/word_ram.sv ====
`timescale 1ns/1ps

module word_ram #(
    parameter int unsigned ram_depth_log2 = 7
) (
    input  logic                       clk,
    input  mem_pkg::mem_req_t          ram_req,
    output logic [mem_pkg::data_w-1:0] rdata
);
    import mem_pkg::*;

    logic [data_w-1:0]         mem [2**ram_depth_log2];
    logic [ram_depth_log2-1:0] idx;
    logic [data_w-1:0]         merged;

    assign idx = ram_req.addr[ram_depth_log2-1:0];   // Upper address bits ignored.

    // Stored word with the masked bytes replaced.
    always_comb begin
        merged = mem[idx];
        for (int b = 0; b < strb_w; b++) begin
            if (ram_req.we && ram_req.wmask[b]) begin
                merged[b*8 +: 8] = ram_req.wdata[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ram_req.en) begin
            if (ram_req.we) begin
                mem[idx] <= merged;
            end
            rdata <= merged;   // A write returns the merged word.
        end
    end

endmodule

// ==== hw/mem_subsys.sv ====
`timescale 1ns/1ps

module mem_subsys #(
    parameter int unsigned ram_depth_log2 = 7
) (
    input  logic              clk,
    input  logic              rst_n,
    input  mem_pkg::apb_req_t fetch_req,
    input  mem_pkg::apb_req_t data_req,
    output mem_pkg::apb_rsp_t fetch_rsp,
    output mem_pkg::apb_rsp_t data_rsp
);
    import mem_pkg::*;

    apb_req_t          lane_req;
    apb_rsp_t          lane_rsp;
    mem_req_t          ram_req;
    logic [data_w-1:0] ram_rdata;

    lane_align i_lane_align (
        .clk      (clk),
        .rst_n    (rst_n),
        .data_req (data_req),
        .lane_req (lane_req),
        .lane_rsp (lane_rsp),
        .data_rsp (data_rsp)
    );

    mem_arbiter i_mem_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .fetch_req (fetch_req),
        .lane_req  (lane_req),
        .fetch_rsp (fetch_rsp),
        .lane_rsp  (lane_rsp),
        .ram_req   (ram_req),
        .ram_rdata (ram_rdata)
    );

    word_ram #(
        .ram_depth_log2 (ram_depth_log2)
    ) i_word_ram (
        .clk     (clk),
        .ram_req (ram_req),
        .rdata   (ram_rdata)
    );

endmodule

// ==== bench/tb_mem_subsys.sv ====
`timescale 1ns/1ps

module tb_mem_subsys;
    import mem_pkg::*;

    localparam int ram_depth_log2 = 7;
    localparam int rst_cycles     = 3;
    localparam int idle_cycles    = 4;
    localparam int row_cycles     = 8;   // Losing side of a tie is the longest row.
    localparam int ready_wait     = 8;
    localparam logic [31:0] use_ref = 'x;

    typedef enum {ON_FETCH, ON_DATA, ON_BOTH} row_port_e;

    typedef struct {
        string       name;
        row_port_e   port;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;       // LSB aligned.
        logic [3:0]  strb;
        logic [31:0] addr2;       // Fetch-side read on a tie row.
        logic [31:0] exp_rdata;
        logic        exp_err;
    } step_t;

    logic     clk;
    logic     rst_n;
    apb_req_t fetch_req;
    apb_req_t data_req;
    apb_rsp_t fetch_rsp;
    apb_rsp_t data_rsp;

    step_t       steps[$];
    logic [31:0] ref_mem [2**ram_depth_log2];
    integer      seed = 32'h4969_3606;
    int          value_errs = 0;
    int          proto_errs = 0;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;
    logic        last_was_fetch;

    mem_subsys #(
        .ram_depth_log2 (ram_depth_log2)
    ) i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .fetch_req (fetch_req),
        .data_req  (data_req),
        .fetch_rsp (fetch_rsp),
        .data_rsp  (data_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout after %0d cycles, the transfers did not complete", cycle_cnt);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic void ref_write(input logic [31:0] addr, input logic [31:0] wdata,
                                      input logic [3:0] strb);
        logic [31:0] data_sh;
        logic [3:0]  strb_sh;
        data_sh = wdata << (8 * addr[1:0]);
        strb_sh = strb << addr[1:0];
        for (int b = 0; b < 4; b++) begin
            if (strb_sh[b]) begin
                ref_mem[addr[ram_depth_log2+1:2]][b*8 +: 8] = data_sh[b*8 +: 8];
            end
        end
    endfunction

    // Fetch sees the whole word, data reads are shifted down.
    function automatic logic [31:0] ref_read(input logic [31:0] addr, input logic on_fetch);
        logic [31:0] word;
        word = ref_mem[addr[ram_depth_log2+1:2]];
        return on_fetch ? word : word >> (8 * addr[1:0]);
    endfunction

    function automatic void add_step(input string name, input row_port_e port,
                                     input logic write, input logic [31:0] addr,
                                     input logic [31:0] wdata, input logic [3:0] strb,
                                     input logic [31:0] addr2, input logic [31:0] exp_rdata,
                                     input logic exp_err);
        step_t s;
        s = '{name, port, write, addr, wdata, strb, addr2, exp_rdata, exp_err};
        steps.push_back(s);
    endfunction

    function automatic void build_steps();
        logic [31:0] addr;
        logic [31:0] data;
        add_step("word_wr_0", ON_DATA, 1, 32'h000, 32'hdeadbeef, 4'hf, 0, use_ref, 0);
        add_step("word_wr_1", ON_DATA, 1, 32'h004, 32'h01234567, 4'hf, 0, use_ref, 0);
        add_step("fetch_rd_0", ON_FETCH, 0, 32'h000, 0, 4'hf, 0, 32'hdeadbeef, 0);
        add_step("fetch_rd_1_off2", ON_FETCH, 0, 32'h006, 0, 4'hf, 0, 32'h01234567, 0);
        add_step("word_wr_4", ON_DATA, 1, 32'h010, 32'h11223344, 4'hf, 0, use_ref, 0);
        add_step("byte_wr_1", ON_DATA, 1, 32'h011, 32'h000000aa, 4'h1, 0, use_ref, 0);
        add_step("half_wr_2", ON_DATA, 1, 32'h012, 32'h0000bbcc, 4'h3, 0, use_ref, 0);
        add_step("byte_wr_3", ON_DATA, 1, 32'h013, 32'h000000dd, 4'h1, 0, use_ref, 0);
        add_step("word_rd_4", ON_DATA, 0, 32'h010, 0, 4'hf, 0, 32'hddccaa44, 0);
        add_step("byte_rd_0", ON_DATA, 0, 32'h010, 0, 4'h1, 0, 32'hddccaa44, 0);
        add_step("byte_rd_1", ON_DATA, 0, 32'h011, 0, 4'h1, 0, 32'h00ddccaa, 0);
        add_step("byte_rd_2", ON_DATA, 0, 32'h012, 0, 4'h1, 0, 32'h0000ddcc, 0);
        add_step("byte_rd_3", ON_DATA, 0, 32'h013, 0, 4'h1, 0, 32'h000000dd, 0);
        add_step("word_wr_5", ON_DATA, 1, 32'h014, 32'h99887766, 4'hf, 0, use_ref, 0);
        add_step("half_wr_1", ON_DATA, 1, 32'h015, 32'h00005566, 4'h3, 0, use_ref, 0);
        add_step("tie_1", ON_BOTH, 1, 32'h020, 32'hcafef00d, 4'hf, 32'h014, use_ref, 0);
        add_step("fetch_rd_8", ON_FETCH, 0, 32'h020, 0, 4'hf, 0, 32'hcafef00d, 0);
        add_step("tie_2", ON_BOTH, 0, 32'h000, 0, 4'hf, 32'h004, use_ref, 0);
        add_step("fetch_wr_err", ON_FETCH, 1, 32'h004, 32'hffffffff, 4'hf, 0, use_ref, 1);
        add_step("fetch_rd_after_err", ON_FETCH, 0, 32'h004, 0, 4'hf, 0, 32'h01234567, 0);
        for (int k = 0; k < 4; k++) begin
            addr = $random(seed) & 32'h0000_0ffc;   // Bits above the RAM depth alias.
            data = $random(seed);
            add_step($sformatf("rand_wr_%0d", k), ON_DATA, 1, addr, data, 4'hf, 0, use_ref, 0);
            add_step($sformatf("rand_rd_data_%0d", k), ON_DATA, 0, addr, 0, 4'hf, 0, data, 0);
            add_step($sformatf("rand_rd_fetch_%0d", k), ON_FETCH, 0, addr, 0, 4'hf, 0, data, 0);
        end
    endfunction

    task automatic check_val(input string name, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("FAILED %s %s: expected %08h, actual %08h", name, what, exp, act);
            value_errs++;
        end
    endtask

    task automatic drive(input logic on_fetch, input apb_req_t req);
        if (on_fetch) begin
            fetch_req <= req;
        end else begin
            data_req <= req;
        end
    endtask

    // One APB transfer, setup then access until pready.
    task automatic apb_xfer(input logic on_fetch, input logic wr, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [3:0] strb,
                            output logic [31:0] rdata, output logic err, output int lat,
                            output logic seen);
        apb_req_t req;
        apb_rsp_t rsp;
        req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr,
                pwdata: wdata, pstrb: strb};
        seen   = 1'b0;
        lat    = 0;
        rdata  = '0;
        err    = 1'b0;
        @(posedge clk);
        drive(on_fetch, req);
        @(posedge clk);
        req.penable = 1'b1;
        drive(on_fetch, req);
        while (!seen && lat < ready_wait) begin
            @(negedge clk);
            lat++;
            rsp = on_fetch ? fetch_rsp : data_rsp;
            if (rsp.pready) begin
                seen   = 1'b1;
                rdata  = rsp.prdata;
                err    = rsp.pslverr;
            end
        end
        @(posedge clk);
        drive(on_fetch, '0);
        assert (seen) else begin
            $display("No pready on the %s port within %0d cycles",
                     on_fetch ? "fetch" : "data", ready_wait);
            proto_errs++;
        end
    endtask

    task automatic run_step(input step_t s);
        logic [31:0] f_rdata, d_rdata, f_exp, d_exp;
        logic        f_err, d_err, f_seen, d_seen, on_fetch, fetch_wins;
        int          f_lat, d_lat;
        if (s.port != ON_BOTH) begin
            on_fetch = (s.port == ON_FETCH);
            d_exp = ref_read(s.addr, on_fetch);
            apb_xfer(on_fetch, s.write, s.addr, s.wdata, s.strb,
                     d_rdata, d_err, d_lat, d_seen);
            if (d_seen) begin
                check_val(s.name, "latency", (on_fetch && s.write) ? 2 : 3, d_lat);
                check_val(s.name, "pslverr", s.exp_err, d_err);
                if (!s.write) begin
                    check_val(s.name, "rdata", d_exp, d_rdata);
                    if (s.exp_rdata !== use_ref) begin
                        check_val(s.name, "table rdata", s.exp_rdata, d_rdata);
                    end
                end
            end
            if (s.write && !on_fetch) begin
                ref_write(s.addr, s.wdata, s.strb);
            end
            last_was_fetch = on_fetch;
        end else begin
            fetch_wins = !last_was_fetch;   // Tie goes to the port not served last.
            f_exp = ref_read(s.addr2, 1'b1);
            d_exp = ref_read(s.addr, 1'b0);
            fork
                apb_xfer(1'b1, 1'b0, s.addr2, '0, 4'hf, f_rdata, f_err, f_lat, f_seen);
                apb_xfer(1'b0, s.write, s.addr, s.wdata, s.strb,
                         d_rdata, d_err, d_lat, d_seen);
            join
            if (f_seen && d_seen) begin
                check_val(s.name, "fetch rdata", f_exp, f_rdata);
                check_val(s.name, "fetch pslverr", 1'b0, f_err);
                check_val(s.name, "data pslverr", s.exp_err, d_err);
                if (!s.write) begin
                    check_val(s.name, "data rdata", d_exp, d_rdata);
                end
                // Both transfers start together, so the shorter wait was served first.
                assert ((f_lat < d_lat) == fetch_wins) else begin
                    $display("%s: the %s port was not served first on the tie",
                             s.name, fetch_wins ? "fetch" : "data");
                    proto_errs++;
                end
            end
            if (s.write) begin
                ref_write(s.addr, s.wdata, s.strb);
            end
            last_was_fetch = !fetch_wins;
        end
    endtask

    initial begin
        fetch_req      = '0;
        data_req       = '0;
        rst_n          = 1'b0;
        last_was_fetch = 1'b0;
        build_steps();
        cycle_limit = steps.size() * row_cycles + rst_cycles + idle_cycles + 4;
        repeat (rst_cycles) @(posedge clk);
        rst_n <= 1'b1;
        repeat (idle_cycles) begin
            @(negedge clk);
            assert (!fetch_rsp.pready && !data_rsp.pready) else begin
                $display("pready went high with no request on either port");
                proto_errs++;
            end
        end
        foreach (steps[i]) begin
            run_step(steps[i]);
        end
        @(posedge clk);
        $display("Errors: %0d value, %0d protocol", value_errs, proto_errs);
        if (value_errs + proto_errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
hw/mem_pkg.sv
hw/lane_align.sv
hw/mem_arbiter.sv
hw/word_ram.sv
hw/mem_subsys.sv
bench/tb_mem_subsys.sv

// ==== Bender.yml ====
package:
  name: mem_subsys

sources:
  - files:
      - hw/mem_pkg.sv
      - hw/lane_align.sv
      - hw/mem_arbiter.sv
      - hw/word_ram.sv
      - hw/mem_subsys.sv
  - target: test
    files:
      - bench/tb_mem_subsys.sv
